//--- sim.f
hdl/axis_router_pkg.sv
hdl/axis_stream_if.sv
hdl/data_pipe_s2m.sv
hdl/axis_interconnect_s2m.sv
hdl/axis_router_top.sv
dv/tb_axis_router.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the axis router testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axis_router -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_axis_router 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- dv/tb_axis_router.sv
// axis router testbench
`timescale 1ns/1ps

module tb_axis_router
    import axis_router_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    // packet mix per test
    localparam int JITTER_PKTS = 8;
    localparam int JITTER_LEN  = 5;
    localparam int BP_PKTS     = 20;
    localparam int BP_LEN      = 4;
    localparam int FREEZE_PKTS = 20;
    localparam int FREEZE_LEN  = 4;
    // directed test sends 1, 3 and 6 beats to every port
    localparam int TOTAL_BEATS = NUM_PORTS * 10 + JITTER_PKTS * JITTER_LEN
                               + BP_PKTS * BP_LEN + FREEZE_PKTS * FREEZE_LEN;
    localparam int SLACK_NS    = 20000;
    localparam int TIMEOUT_NS  = TOTAL_BEATS * CLK_PERIOD * 3 / 2 + SLACK_NS;

    logic                 clock = 1'b0;
    logic                 rst_n;
    logic                 clk_en;
    logic [PORT_BITS-1:0] addr;
    logic [DATA_BITS-1:0] s_tdata;
    logic                 s_tvalid;
    logic                 s_tlast;
    logic                 s_tuser;
    logic [KEEP_BITS-1:0] s_tkeep;
    logic                 s_tready;
    logic [DATA_BITS-1:0] m_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0] m_tvalid;
    logic [NUM_PORTS-1:0] m_tlast;
    logic [NUM_PORTS-1:0] m_tuser;
    logic [KEEP_BITS-1:0] m_tkeep [NUM_PORTS];
    logic [NUM_PORTS-1:0] m_tready;

    // stimulus knobs that change on clock edges
    logic gaps_on   = 1'b0;
    logic jitter_on = 1'b0;
    logic bp_on     = 1'b0;
    logic en_jitter = 1'b0;
    int   en_low_left = 0;
    string test_name = "reset";

    // scoreboard keeps one queue of expected beats per port
    logic [BEAT_BITS-1:0] exp_q [NUM_PORTS][$];
    logic                 sb_locked;
    logic [PORT_BITS-1:0] sb_port;
    logic [NUM_PORTS-1:0] have_beat;
    logic [BEAT_BITS-1:0] head_word [NUM_PORTS];

    // output words and what they looked like one edge ago
    logic [BEAT_BITS-1:0] got_word [NUM_PORTS];
    logic [BEAT_BITS-1:0] prev_word [NUM_PORTS];
    logic [NUM_PORTS-1:0] prev_valid;
    logic [NUM_PORTS-1:0] held;
    logic                 was_frozen;

    always #(CLK_PERIOD / 2) clock = ~clock;

    axis_router_top DUT (
        .clock    (clock),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .addr     (addr),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .s_tkeep  (s_tkeep),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tkeep  (m_tkeep),
        .m_tready (m_tready)
    );

    // sink ready is high about three quarters of the time under back-pressure
    initial begin
        m_tready = '1;
        forever begin
            @(posedge clock);
            if (bp_on) begin
                m_tready <= NUM_PORTS'($urandom) | NUM_PORTS'($urandom);
            end else begin
                m_tready <= '1;
            end
        end
    end

    // clock enable drops for stretches of 1 to 5 cycles
    initial begin
        clk_en = 1'b1;
        forever begin
            @(posedge clock);
            if (en_low_left > 0) begin
                clk_en      <= 1'b0;
                en_low_left <= en_low_left - 1;
            end else if (en_jitter && $urandom_range(0, 7) == 0) begin
                clk_en      <= 1'b0;
                en_low_left <= $urandom_range(0, 4);
            end else begin
                clk_en <= 1'b1;
            end
        end
    end

    // reference model of the route lock
    always @(posedge clock) begin
        logic [PORT_BITS-1:0] dst;
        if (!rst_n) begin
            sb_locked <= 1'b0;
            sb_port   <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                exp_q[p].delete();
            end
        end else if (clk_en) begin
            // drained beats leave first so a reload lands behind them
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (m_tvalid[p] && m_tready[p] && exp_q[p].size() != 0) begin
                    void'(exp_q[p].pop_front());
                end
            end
            if (s_tvalid && s_tready) begin
                // first beat picks the port and the rest follow it
                dst = sb_locked ? sb_port : addr;
                exp_q[dst].push_back({s_tkeep, s_tuser, s_tlast, s_tdata});
                sb_locked <= !s_tlast;
                sb_port   <= dst;
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            have_beat[p] <= exp_q[p].size() != 0;
            head_word[p] <= (exp_q[p].size() != 0) ? exp_q[p][0] : '0;
        end
    end

    // history for the hold and freeze checks
    always @(posedge clock) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            held[p] <= m_tvalid[p] && !(clk_en && m_tready[p]);
        end
        prev_word  <= got_word;
        prev_valid <= m_tvalid;
        was_frozen <= !clk_en;
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_check
        assign got_word[p] = {m_tkeep[p], m_tuser[p], m_tlast[p], m_tdata[p]};

        // each beat leaving a port is the oldest one routed there
        assert property (@(posedge clock) disable iff (!rst_n)
            (clk_en && m_tvalid[p] && m_tready[p])
                |-> (have_beat[p] && got_word[p] == head_word[p]))
        else begin
            $display("CHECK FAILED %s port %0d expected %h actual %h", test_name, p,
                $sampled(head_word[p]), $sampled(got_word[p]));
            $display("Finished with errors");
            $fatal(1);
        end

        // a waiting beat keeps valid and payload
        assert property (@(posedge clock) disable iff (!rst_n)
            held[p] |-> (m_tvalid[p] && got_word[p] == prev_word[p]))
        else begin
            $display("CHECK FAILED %s port %0d held beat expected %h actual %h", test_name,
                p, $sampled(prev_word[p]), $sampled(got_word[p]));
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // nothing moves across an edge with clk_en low
    assert property (@(posedge clock) disable iff (!rst_n)
        was_frozen |-> (m_tvalid == prev_valid))
    else begin
        $display("CHECK FAILED %s m_tvalid expected %b actual %b", test_name,
            $sampled(prev_valid), $sampled(m_tvalid));
        $display("Finished with errors");
        $fatal(1);
    end

    // one packet with each beat held until the router takes it
    task automatic send_packet(input logic [PORT_BITS-1:0] port, input int len);
        for (int b = 0; b < len; b++) begin
            if (gaps_on && $urandom_range(0, 3) == 0) begin
                s_tvalid <= 1'b0;
                if (jitter_on) begin
                    addr <= PORT_BITS'($urandom);
                end
                @(posedge clock);
            end
            s_tvalid <= 1'b1;
            s_tdata  <= DATA_BITS'($urandom);
            s_tlast  <= (b == len - 1);
            s_tuser  <= (b == 0);
            s_tkeep  <= KEEP_BITS'($urandom);
            if (b == 0 || !jitter_on) begin
                addr <= port;
            end else begin
                addr <= PORT_BITS'($urandom);
            end
            do begin
                @(posedge clock);
                // addr is free to wander once the packet is open
                if (jitter_on && b > 0) begin
                    addr <= PORT_BITS'($urandom);
                end
            end while (!(clk_en && s_tready));
        end
        s_tvalid <= 1'b0;
    endtask

    // watchdog sized from the total beat count
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the traffic finished");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        int leftover;
        rst_n    = 1'b0;
        addr     = '0;
        s_tdata  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
        s_tkeep  = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        void'($urandom(32'hd1b7));
        @(negedge clock);
        assert (m_tvalid == '0 && s_tready == 1'b1) else begin
            $display("CHECK FAILED %s expected m_tvalid 0 s_tready 1 actual %b %b",
                test_name, m_tvalid, s_tready);
            $display("Finished with errors");
            $fatal(1);
        end
        @(posedge clock);
        test_name <= "directed";
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_packet(PORT_BITS'(p), 1);
            send_packet(PORT_BITS'(p), 3);
            send_packet(PORT_BITS'(p), 6);
        end
        // addr also wanders while valid drops inside a packet
        test_name <= "addr_jitter";
        jitter_on <= 1'b1;
        gaps_on   <= 1'b1;
        repeat (JITTER_PKTS) send_packet(PORT_BITS'($urandom), JITTER_LEN);
        test_name <= "backpressure";
        jitter_on <= 1'b0;
        bp_on     <= 1'b1;
        gaps_on   <= 1'b1;
        repeat (BP_PKTS) send_packet(PORT_BITS'($urandom), BP_LEN);
        test_name <= "clk_en_freeze";
        en_jitter <= 1'b1;
        repeat (FREEZE_PKTS) send_packet(PORT_BITS'($urandom), FREEZE_LEN);
        // let every port drain
        test_name <= "drain";
        bp_on     <= 1'b0;
        gaps_on   <= 1'b0;
        en_jitter <= 1'b0;
        @(posedge clock);
        while (m_tvalid != '0 || !clk_en) begin
            @(posedge clock);
        end
        @(negedge clock);
        leftover = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            leftover += exp_q[p].size();
        end
        if (leftover != 0) begin
            $display("%0d routed beats never came out of the router", leftover);
            $display("Finished with errors");
            $fatal(1);
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- hdl/axis_router_top.sv
// axis router top level
`timescale 1ns/1ps

module axis_router_top
    import axis_router_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic [PORT_BITS-1:0] addr,

    // source stream
    input  logic [DATA_BITS-1:0] s_tdata,
    input  logic                 s_tvalid,
    input  logic                 s_tlast,
    input  logic                 s_tuser,
    input  logic [KEEP_BITS-1:0] s_tkeep,
    output logic                 s_tready,

    // sink streams, one element per port
    output logic [DATA_BITS-1:0] m_tdata [NUM_PORTS],
    output logic [NUM_PORTS-1:0] m_tvalid,
    output logic [NUM_PORTS-1:0] m_tlast,
    output logic [NUM_PORTS-1:0] m_tuser,
    output logic [KEEP_BITS-1:0] m_tkeep [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] m_tready
);

    // stream bundles inside the design
    axis_stream_if s_axis ();
    axis_stream_if m_axis [NUM_PORTS] ();

    // source side
    assign s_axis.tdata  = s_tdata;
    assign s_axis.tvalid = s_tvalid;
    assign s_axis.tlast  = s_tlast;
    assign s_axis.tuser  = s_tuser;
    assign s_axis.tkeep  = s_tkeep;
    assign s_tready      = s_axis.tready;

    // sink sides
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign m_tdata[p]       = m_axis[p].tdata;
        assign m_tvalid[p]      = m_axis[p].tvalid;
        assign m_tlast[p]       = m_axis[p].tlast;
        assign m_tuser[p]       = m_axis[p].tuser;
        assign m_tkeep[p]       = m_axis[p].tkeep;
        assign m_axis[p].tready = m_tready[p];
    end

    // router
    axis_interconnect_s2m u_interconnect (
        .clock  (clock),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .addr   (addr),
        .s00    (s_axis),
        .m00    (m_axis)
    );

endmodule

//--- hdl/axis_interconnect_s2m.sv
// axi stream one to many interconnect
`timescale 1ns/1ps

module axis_interconnect_s2m
    import axis_router_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic [PORT_BITS-1:0] addr,

    axis_stream_if.slave         s00,
    axis_stream_if.master        m00 [NUM_PORTS]
);

    // packed beats around the core
    logic                 pipe_in_valid;
    logic [BEAT_BITS-1:0] pipe_in_data;
    logic                 pipe_in_ready;
    logic [NUM_PORTS-1:0] pipe_out_valid;
    logic [BEAT_BITS-1:0] pipe_out_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] pipe_out_ready;

    // keep, user, last, data from high bits to low bits
    assign pipe_in_data  = {s00.tkeep, s00.tuser, s00.tlast, s00.tdata};
    assign pipe_in_valid = s00.tvalid;
    assign s00.tready    = pipe_in_ready;

    // unpack each port word back into stream fields
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign m00[p].tvalid     = pipe_out_valid[p];
        assign m00[p].tdata      = pipe_out_data[p][DATA_BITS-1:0];
        assign m00[p].tlast      = pipe_out_data[p][DATA_BITS];
        assign m00[p].tuser      = pipe_out_data[p][DATA_BITS+1];
        assign m00[p].tkeep      = pipe_out_data[p][DATA_BITS+2 +: KEEP_BITS];
        assign pipe_out_ready[p] = m00[p].tready;
    end

    // routing and per port registers
    data_pipe_s2m u_pipe (
        .clock     (clock),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .addr      (addr),
        .in_valid  (pipe_in_valid),
        .in_data   (pipe_in_data),
        .in_ready  (pipe_in_ready),
        .out_valid (pipe_out_valid),
        .out_data  (pipe_out_data),
        .out_ready (pipe_out_ready)
    );

endmodule

//--- hdl/data_pipe_s2m.sv
// one to many beat router core
`timescale 1ns/1ps

module data_pipe_s2m
    import axis_router_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic [PORT_BITS-1:0] addr,

    // input beat
    input  logic                 in_valid,
    input  logic [BEAT_BITS-1:0] in_data,
    output logic                 in_ready,

    // per port output beats
    output logic [NUM_PORTS-1:0] out_valid,
    output logic [BEAT_BITS-1:0] out_data [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] out_ready
);

    // route lock
    route_state_e         state;
    logic [PORT_BITS-1:0] lock_port;

    // port the current input beat is headed for
    logic [PORT_BITS-1:0] target_port;

    // input beat accepted this cycle
    logic                 accept;

    // last flag sits right above the data field
    logic                 in_last;

    assign in_last = in_data[DATA_BITS];

    // new packets follow addr, open packets stay on the latched port
    always_comb begin
        if (state == ROUTE_IDLE) begin
            target_port = addr;
        end else begin
            target_port = lock_port;
        end
    end

    // room when the target register is empty or drains this cycle
    // never looks at in_valid
    assign in_ready = ~out_valid[target_port] | out_ready[target_port];

    // nothing counts while clk_en is low
    assign accept = clk_en & in_valid & in_ready;

    // lock FSM
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= ROUTE_IDLE;
            lock_port <= '0;
        end else if (accept) begin
            // latch the port on the first beat of a packet
            if (state == ROUTE_IDLE) begin
                lock_port <= addr;
            end
            // tlast closes the packet, anything else keeps it open
            if (in_last) begin
                state <= ROUTE_IDLE;
            end else begin
                state <= ROUTE_LOCKED;
            end
        end
    end

    // output valid flags
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else if (clk_en) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (accept && (target_port == PORT_BITS'(i))) begin
                    // reload wins over drain
                    out_valid[i] <= 1'b1;
                end else if (out_ready[i]) begin
                    // drained with nothing behind it
                    out_valid[i] <= 1'b0;
                end
            end
        end
    end

    // output payload registers
    always_ff @(posedge clock) begin
        if (clk_en) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                // hold while waiting on ready
                if (accept && (target_port == PORT_BITS'(i))) begin
                    out_data[i] <= in_data;
                end
            end
        end
    end

endmodule

//--- hdl/axis_stream_if.sv
// axi stream interface
`timescale 1ns/1ps

interface axis_stream_if
    import axis_router_pkg::*;
();

    // payload fields travel together on every beat
    logic [DATA_BITS-1:0] tdata;
    logic                 tlast;
    logic                 tuser;
    logic [KEEP_BITS-1:0] tkeep;

    // handshake
    logic                 tvalid;
    logic                 tready;

    // source side drives payload and valid
    modport master (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        output tkeep,
        input  tready
    );

    // sink side mirrors the source
    modport slave (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        input  tkeep,
        output tready
    );

endinterface

//--- hdl/axis_router_pkg.sv
// axis router shared definitions
package axis_router_pkg;

    // number of master streams fed by the router
    localparam int NUM_PORTS = 4;

    // width of the port address
    localparam int PORT_BITS = 2;

    // tdata width in bits
    localparam int DATA_BITS = 8;

    // one keep bit per tdata byte
    localparam int KEEP_BITS = 1;

    // packed beat is keep, user, last and data from high to low
    localparam int BEAT_BITS = DATA_BITS + 1 + 1 + KEEP_BITS;

    // route lock state
    typedef enum logic {
        // no packet open
        ROUTE_IDLE   = 1'b0,
        // packet open on the latched port
        ROUTE_LOCKED = 1'b1
    } route_state_e;

endpackage
